// File: bench/tb_vectors.svh
// ----------------------------------------------------------
// Bus transfer table for the iomem peripheral testbench
// ----------------------------------------------------------
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: name, addr, wstrb (0 = read), wdata, random wdata, expect from model, expected rdata
localparam int NAME_CHARS = 12;
localparam int NUM_VECS   = 26;

typedef struct packed {
    logic [8*NAME_CHARS-1:0] name;
    logic [31:0]             addr;
    logic [3:0]              wstrb;
    logic [31:0]             wdata;
    logic                    rand_data;
    logic                    use_model;
    logic [31:0]             exp;
} vec_t;

vec_t vec_table [NUM_VECS] = '{
    '{"ram_wr_w0",   32'h1000_0000, 4'hF, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000},
    '{"ram_wr_w1",   32'h1000_0004, 4'hF, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000},
    '{"ram_wr_top",  32'h1000_03FC, 4'hF, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000},
    '{"ram_rd_w0",   32'h1000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0000},
    '{"ram_rd_w1",   32'h1000_0004, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0000},
    '{"ram_rd_top",  32'h1000_03FC, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0000},
    '{"ram_wr_b02",  32'h1000_0000, 4'h5, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000},
    '{"ram_wr_b3",   32'h1000_0004, 4'h8, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000},
    '{"ram_rd_m0",   32'h1000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0000},
    '{"ram_rd_m1",   32'h1000_0004, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0000},
    '{"gpio_dir_wr", 32'h2000_0000, 4'hF, 32'h0000_00C3, 1'b0, 1'b0, 32'h0000_0000},
    '{"gpio_out_wr", 32'h2000_0008, 4'h1, 32'hFFFF_FF96, 1'b0, 1'b0, 32'h0000_0000},
    '{"gpio_dir_rd", 32'h2000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_00C3},
    '{"gpio_out_rd", 32'h2000_0008, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0096},
    '{"gpio_in_rd",  32'h2000_0004, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_005A},
    '{"led_fb_wr",   32'h3000_0000, 4'hF, 32'hF00F_A55A, 1'b0, 1'b0, 32'h0000_0000},
    '{"led_fb_rd",   32'h3000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 32'hF00F_A55A},
    '{"none_rd",     32'h4000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000},
    '{"none_wr_gp",  32'h2000_000C, 4'hF, 32'hFFFF_FFFF, 1'b0, 1'b0, 32'h0000_0000},
    '{"none_wr_ram", 32'h1000_0400, 4'hF, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000},
    '{"none_wr_led", 32'h3000_0004, 4'hF, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000},
    '{"chk_dir_rd",  32'h2000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_00C3},
    '{"chk_out_rd",  32'h2000_0008, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0096},
    '{"chk_led_rd",  32'h3000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 32'hF00F_A55A},
    '{"chk_ram_rd",  32'h1000_0000, 4'h0, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0000},
    '{"none_rd_hi",  32'hFFFF_FFFC, 4'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000}
};

`endif

// File: bench/tb_iomem_periph_top.sv
// ----------------------------------------------------------
// Testbench for the iomem peripheral subsystem
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_iomem_periph_top;
    import soc_io_pkg::*;

    localparam int                 CLK_PERIOD     = 8;
    localparam int                 RESET_CYCLES   = 8;
    localparam int                 CYCLES_PER_VEC = 20;
    localparam int                 HOLD_CYCLES    = 2;
    localparam int                 READY_LIMIT    = 16;
    localparam logic [GPIO_NR-1:0] GPIO_IN_VALUE  = 8'h5A;

    logic                    clk;
    logic                    arst_n;
    logic                    iomem_valid;
    logic [IOMEM_STRB_W-1:0] iomem_wstrb;
    logic [IOMEM_ADDR_W-1:0] iomem_addr;
    logic [IOMEM_DATA_W-1:0] iomem_wdata;
    logic                    iomem_ready;
    logic [IOMEM_DATA_W-1:0] iomem_rdata;
    logic [GPIO_NR-1:0]      gpio_in;
    logic [GPIO_NR-1:0]      gpio_out;
    logic [GPIO_NR-1:0]      gpio_oe;
    logic [LED_COLS-1:0]     led_row_n;
    logic [LED_ROWS-1:0]     led_col_n;

    `include "tb_vectors.svh"

    // Reference state built from the register rules
    logic [IOMEM_DATA_W-1:0] m_ram [RAM_WORDS];
    logic [GPIO_NR-1:0]      m_dir;
    logic [GPIO_NR-1:0]      m_out;
    logic [IOMEM_DATA_W-1:0] m_fb;
    logic [15:0]             lfsr_state;

    iomem_periph_top DUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .iomem_valid (iomem_valid),
        .iomem_wstrb (iomem_wstrb),
        .iomem_addr  (iomem_addr),
        .iomem_wdata (iomem_wdata),
        .iomem_ready (iomem_ready),
        .iomem_rdata (iomem_rdata),
        .gpio_in     (gpio_in),
        .gpio_out    (gpio_out),
        .gpio_oe     (gpio_oe),
        .led_row_n   (led_row_n),
        .led_col_n   (led_col_n)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Watchdog
    initial begin
        #((RESET_CYCLES + CYCLES_PER_VEC * NUM_VECS) * CLK_PERIOD);
        fail_and_stop("Timeout: the bus transfers did not finish in time");
    end

    // ------------------------------------------------------
    // Helpers
    // ------------------------------------------------------
    task automatic fail_and_stop(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input logic [8*NAME_CHARS-1:0] name,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            fail_and_stop($sformatf("CHECK FAILED: %0s expected %h actual %h",
                                    name, expected, actual));
        end
    endtask

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 16'hB400;
        end
        return nxt;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word       = {word[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return word;
    endfunction

    function automatic bit in_ram_window(input logic [31:0] addr);
        return (addr >= RAM_BASE) && (addr < RAM_BASE + RAM_WORDS * 4);
    endfunction

    task automatic update_model(input logic [31:0] addr, input logic [3:0] wstrb,
                                input logic [31:0] wdata);
        int idx;
        if (in_ram_window(addr)) begin
            idx = int'((addr - RAM_BASE) >> 2);
            for (int lane = 0; lane < 4; lane++) begin
                if (wstrb[lane]) begin
                    m_ram[idx][8*lane +: 8] = wdata[8*lane +: 8];
                end
            end
        end else if (addr == GPIO_DIR_ADDR) begin
            m_dir = wdata[GPIO_NR-1:0];
        end else if (addr == GPIO_OUTPUT_ADDR) begin
            m_out = wdata[GPIO_NR-1:0];
        end else if (addr == LED_FB_ADDR) begin
            m_fb = wdata;
        end
    endtask

    // Expected RAM word after the merged byte-lane writes
    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (in_ram_window(addr)) begin
            return m_ram[int'((addr - RAM_BASE) >> 2)];
        end
        return 32'h0;
    endfunction

    // One full frame, every lit row against the frame buffer
    task automatic check_scan();
        logic [LED_ROWS-1:0] seen;
        logic [LED_COLS-1:0] exp_row;
        int                  row;
        seen = '0;
        for (int cyc = 0; cyc < LED_ROWS * LED_SCAN_DIV; cyc++) begin
            @(negedge clk);
            check_value("scan_onecold", 1, $countones(~led_col_n));
            row = 0;
            for (int r = 0; r < LED_ROWS; r++) begin
                if (!led_col_n[r]) begin
                    row = r;
                end
            end
            exp_row = ~m_fb[8*row +: 8];
            check_value("scan_row", exp_row, led_row_n);
            seen[row] = 1'b1;
        end
        check_value("scan_all_rows", {LED_ROWS{1'b1}}, seen);
    endtask

    // Called on a falling edge, returns on a falling edge with valid low
    task automatic run_transfer(input vec_t v, input logic [31:0] wr_data,
                                output int latency, output logic [31:0] rdata);
        int waited;
        iomem_valid = 1'b1;
        iomem_addr  = v.addr;
        iomem_wstrb = v.wstrb;
        iomem_wdata = wr_data;
        waited      = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!iomem_ready && waited < READY_LIMIT);
        // Rising edges counted after the accepting edge
        latency = waited - 1;
        rdata   = iomem_rdata;
        // Valid still held, no second ready allowed
        for (int h = 0; h < HOLD_CYCLES; h++) begin
            @(negedge clk);
            check_value(v.name, 0, iomem_ready);
        end
        iomem_valid = 1'b0;
        iomem_addr  = '0;
        iomem_wstrb = '0;
        iomem_wdata = '0;
        @(negedge clk);
    endtask

    // ------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------
    initial begin
        vec_t        v;
        logic [31:0] wr_data;
        logic [31:0] expected;
        logic [31:0] rdata;
        int          latency;
        clk         = 1'b0;
        arst_n      = 1'b0;
        iomem_valid = 1'b0;
        iomem_wstrb = '0;
        iomem_addr  = '0;
        iomem_wdata = '0;
        gpio_in     = '0;
        lfsr_state  = 16'd10;
        m_dir       = '0;
        m_out       = '0;
        m_fb        = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        // Reset values, sampled while reset is still held
        check_value("reset_ready", 0, iomem_ready);
        check_value("reset_rdata", 0, iomem_rdata);
        check_value("reset_oe", 0, gpio_oe);
        check_value("reset_out", 0, gpio_out);
        check_value("reset_row_n", 8'hFF, led_row_n);
        check_value("reset_col_n", 4'hE, led_col_n);
        arst_n  = 1'b1;
        gpio_in = GPIO_IN_VALUE;
        @(negedge clk);

        for (int i = 0; i < NUM_VECS; i++) begin
            v       = vec_table[i];
            wr_data = v.rand_data ? random_word() : v.wdata;
            run_transfer(v, wr_data, latency, rdata);
            check_value(v.name, 2, latency);
            if (v.wstrb != 4'h0) begin
                update_model(v.addr, v.wstrb, wr_data);
            end else begin
                expected = v.use_model ? model_read(v.addr) : v.exp;
                check_value(v.name, expected, rdata);
            end
            check_value(v.name, m_dir, gpio_oe);
            check_value(v.name, m_out, gpio_out);
            if (v.addr[31:28] == 4'h3) begin
                check_scan();
            end
        end
        check_scan();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+bench
source/soc_io_pkg.sv
source/iomem_req_if.sv
source/iomem_addr_decode.sv
source/scratch_ram.sv
source/gpio_ctrl.sv
source/led_fb_scan.sv
source/iomem_resp_mux.sv
source/iomem_periph_top.sv
bench/tb_iomem_periph_top.sv

// File: source/gpio_ctrl.sv
// ----------------------------------------------------------
// GPIO controller with direction, output and synced input
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl (
    input  logic                                clk,
    input  logic                                arst_n,
    iomem_req_if.target                         req,
    input  logic [soc_io_pkg::GPIO_NR-1:0]      gpio_in,
    output logic [soc_io_pkg::GPIO_NR-1:0]      gpio_out,
    output logic [soc_io_pkg::GPIO_NR-1:0]      gpio_oe,
    output logic [soc_io_pkg::IOMEM_DATA_W-1:0] rdata
);
    import soc_io_pkg::*;

    logic [GPIO_NR-1:0] dir_q;
    logic [GPIO_NR-1:0] out_q;
    logic [GPIO_NR-1:0] in_meta;
    logic [GPIO_NR-1:0] in_sync;
    logic               sel;

    assign sel      = req.strobe && (req.tgt == TGT_GPIO);
    assign gpio_oe  = dir_q;
    assign gpio_out = out_q;

    // ------------------------------------------------------
    // Registers and input synchronizer
    // ------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dir_q   <= '0;
            out_q   <= '0;
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
            if (sel && |req.wstrb) begin
                if (req.addr == GPIO_DIR_ADDR[IOMEM_ADDR_W-1:2]) begin
                    dir_q <= req.wdata[GPIO_NR-1:0];
                end
                if (req.addr == GPIO_OUTPUT_ADDR[IOMEM_ADDR_W-1:2]) begin
                    out_q <= req.wdata[GPIO_NR-1:0];
                end
            end
        end
    end

    // ------------------------------------------------------
    // Read back, zero extended
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (sel) begin
            case (req.addr)
                GPIO_DIR_ADDR[IOMEM_ADDR_W-1:2]:    rdata <= IOMEM_DATA_W'(dir_q);
                GPIO_INPUT_ADDR[IOMEM_ADDR_W-1:2]:  rdata <= IOMEM_DATA_W'(in_sync);
                GPIO_OUTPUT_ADDR[IOMEM_ADDR_W-1:2]: rdata <= IOMEM_DATA_W'(out_q);
                default:                            rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/iomem_addr_decode.sv
// ----------------------------------------------------------
// iomem address decoder, one registered strobe per request
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module iomem_addr_decode (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                iomem_valid,
    input  logic [soc_io_pkg::IOMEM_STRB_W-1:0] iomem_wstrb,
    input  logic [soc_io_pkg::IOMEM_ADDR_W-1:0] iomem_addr,
    input  logic [soc_io_pkg::IOMEM_DATA_W-1:0] iomem_wdata,
    iomem_req_if.decoder                        req
);
    import soc_io_pkg::*;

    logic          busy;
    logic          accept;
    iomem_target_e target_sel;

    // Held request is taken once, busy drops only when valid falls
    assign accept = iomem_valid && !busy;

    always_comb begin
        if (iomem_addr >= RAM_BASE && iomem_addr < RAM_LIMIT) begin
            target_sel = TGT_RAM;
        end else if (iomem_addr == GPIO_DIR_ADDR ||
                     iomem_addr == GPIO_INPUT_ADDR ||
                     iomem_addr == GPIO_OUTPUT_ADDR) begin
            target_sel = TGT_GPIO;
        end else if (iomem_addr == LED_FB_ADDR) begin
            target_sel = TGT_LED;
        end else begin
            // Unmapped, still answered by the response stage
            target_sel = TGT_NONE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            req.strobe <= 1'b0;
        end else begin
            req.strobe <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (!iomem_valid) begin
                busy <= 1'b0;
            end
        end
    end

    // Request fields
    always_ff @(posedge clk) begin
        if (accept) begin
            req.tgt   <= target_sel;
            req.addr  <= iomem_addr[IOMEM_ADDR_W-1:2];
            req.wstrb <= iomem_wstrb;
            req.wdata <= iomem_wdata;
        end
    end

endmodule

`default_nettype wire

// File: source/iomem_periph_top.sv
// ----------------------------------------------------------
// iomem peripheral subsystem with scratch RAM, GPIO and LED
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module iomem_periph_top (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                iomem_valid,
    input  logic [soc_io_pkg::IOMEM_STRB_W-1:0] iomem_wstrb,
    input  logic [soc_io_pkg::IOMEM_ADDR_W-1:0] iomem_addr,
    input  logic [soc_io_pkg::IOMEM_DATA_W-1:0] iomem_wdata,
    output logic                                iomem_ready,
    output logic [soc_io_pkg::IOMEM_DATA_W-1:0] iomem_rdata,
    input  logic [soc_io_pkg::GPIO_NR-1:0]      gpio_in,
    output logic [soc_io_pkg::GPIO_NR-1:0]      gpio_out,
    output logic [soc_io_pkg::GPIO_NR-1:0]      gpio_oe,
    output logic [soc_io_pkg::LED_COLS-1:0]     led_row_n,
    output logic [soc_io_pkg::LED_ROWS-1:0]     led_col_n
);
    import soc_io_pkg::*;

    logic [IOMEM_DATA_W-1:0] ram_rdata;
    logic [IOMEM_DATA_W-1:0] gpio_rdata;
    logic [IOMEM_DATA_W-1:0] led_rdata;

    iomem_req_if req ();

    // Decode stage
    iomem_addr_decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .iomem_valid (iomem_valid),
        .iomem_wstrb (iomem_wstrb),
        .iomem_addr  (iomem_addr),
        .iomem_wdata (iomem_wdata),
        .req         (req.decoder)
    );

    // Execute stage
    scratch_ram u_ram (
        .clk   (clk),
        .req   (req.target),
        .rdata (ram_rdata)
    );

    gpio_ctrl u_gpio (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req.target),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe),
        .rdata    (gpio_rdata)
    );

    led_fb_scan u_led (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req.target),
        .rdata     (led_rdata),
        .led_row_n (led_row_n),
        .led_col_n (led_col_n)
    );

    // Result stage
    iomem_resp_mux u_resp (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req.target),
        .ram_rdata   (ram_rdata),
        .gpio_rdata  (gpio_rdata),
        .led_rdata   (led_rdata),
        .iomem_ready (iomem_ready),
        .iomem_rdata (iomem_rdata)
    );

endmodule

`default_nettype wire

// File: source/iomem_req_if.sv
// ----------------------------------------------------------
// Decoded iomem request, one strobe per accepted transfer
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface iomem_req_if;
    import soc_io_pkg::*;

    logic                     strobe;
    iomem_target_e            tgt;
    logic [IOMEM_WADDR_W-1:0] addr;
    logic [IOMEM_STRB_W-1:0]  wstrb;
    logic [IOMEM_DATA_W-1:0]  wdata;

    modport decoder (
        output strobe,
        output tgt,
        output addr,
        output wstrb,
        output wdata
    );

    modport target (
        input strobe,
        input tgt,
        input addr,
        input wstrb,
        input wdata
    );

endinterface

`default_nettype wire

// File: source/iomem_resp_mux.sv
// ----------------------------------------------------------
// Response stage, registers ready and the selected rdata
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module iomem_resp_mux (
    input  logic                                clk,
    input  logic                                arst_n,
    iomem_req_if.target                         req,
    input  logic [soc_io_pkg::IOMEM_DATA_W-1:0] ram_rdata,
    input  logic [soc_io_pkg::IOMEM_DATA_W-1:0] gpio_rdata,
    input  logic [soc_io_pkg::IOMEM_DATA_W-1:0] led_rdata,
    output logic                                iomem_ready,
    output logic [soc_io_pkg::IOMEM_DATA_W-1:0] iomem_rdata
);
    import soc_io_pkg::*;

    logic                    strobe_d;
    iomem_target_e           target_d;
    logic [IOMEM_DATA_W-1:0] rdata_sel;

    // Peripheral read data lands one cycle after the strobe
    always_comb begin
        case (target_d)
            TGT_RAM:  rdata_sel = ram_rdata;
            TGT_GPIO: rdata_sel = gpio_rdata;
            TGT_LED:  rdata_sel = led_rdata;
            default:  rdata_sel = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            strobe_d    <= 1'b0;
            target_d    <= TGT_NONE;
            iomem_ready <= 1'b0;
            iomem_rdata <= '0;
        end else begin
            strobe_d    <= req.strobe;
            target_d    <= req.tgt;
            iomem_ready <= strobe_d;
            // Bus reads zero outside the ready cycle
            iomem_rdata <= strobe_d ? rdata_sel : '0;
        end
    end

endmodule

`default_nettype wire

// File: source/led_fb_scan.sv
// ----------------------------------------------------------
// LED matrix frame buffer and row-scanning display driver
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module led_fb_scan (
    input  logic                                clk,
    input  logic                                arst_n,
    iomem_req_if.target                         req,
    output logic [soc_io_pkg::IOMEM_DATA_W-1:0] rdata,
    output logic [soc_io_pkg::LED_COLS-1:0]     led_row_n,
    output logic [soc_io_pkg::LED_ROWS-1:0]     led_col_n
);
    import soc_io_pkg::*;

    led_fb_word_u          fb;
    logic [LED_SCAN_CNT_W-1:0] div_cnt;
    logic [LED_ROW_W-1:0]  row_idx;
    logic                  sel;

    assign sel = req.strobe && (req.tgt == TGT_LED);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fb      <= '0;
            div_cnt <= '0;
            row_idx <= '0;
        end else begin
            if (sel && |req.wstrb) begin
                fb.word <= req.wdata;
            end
            // Each row stays lit for LED_SCAN_DIV cycles
            if (div_cnt == LED_SCAN_CNT_W'(LED_SCAN_DIV - 1)) begin
                div_cnt <= '0;
                row_idx <= (row_idx == LED_ROW_W'(LED_ROWS - 1)) ? '0 : row_idx + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            rdata <= fb.word;
        end
    end

    // Active low drive, one column line low per scanned row
    assign led_col_n = ~(LED_ROWS'(1) << row_idx);
    assign led_row_n = ~fb.rows[row_idx];

endmodule

`default_nettype wire

// File: source/scratch_ram.sv
// ----------------------------------------------------------
// Scratch RAM with byte-lane writes and registered reads
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
    input  logic                                clk,
    iomem_req_if.target                         req,
    output logic [soc_io_pkg::IOMEM_DATA_W-1:0] rdata
);
    import soc_io_pkg::*;

    logic [IOMEM_DATA_W-1:0] mem [RAM_WORDS];
    logic [RAM_ADDR_W-1:0]   word_idx;
    logic                    sel;

    // Window check is done by the decoder, low bits index the array
    assign word_idx = req.addr[RAM_ADDR_W-1:0];
    assign sel      = req.strobe && (req.tgt == TGT_RAM);

    always_ff @(posedge clk) begin
        if (sel) begin
            for (int lane = 0; lane < IOMEM_STRB_W; lane++) begin
                if (req.wstrb[lane]) begin
                    mem[word_idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
                end
            end
            // Old contents on a write cycle, only reads use this
            rdata <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// File: source/soc_io_pkg.sv
// ----------------------------------------------------------
// SoC peripheral package with bus widths, address map and
// the types shared by the iomem decode and peripheral blocks
// ----------------------------------------------------------
`default_nettype none

package soc_io_pkg;

    // Bus widths
    localparam int IOMEM_ADDR_W  = 32;
    localparam int IOMEM_DATA_W  = 32;
    localparam int IOMEM_STRB_W  = 4;
    localparam int IOMEM_WADDR_W = IOMEM_ADDR_W - 2;

    // Scratch RAM window, word addressed
    localparam logic [IOMEM_ADDR_W-1:0] RAM_BASE  = 32'h1000_0000;
    localparam int                      RAM_WORDS = 256;
    localparam int                      RAM_ADDR_W = $clog2(RAM_WORDS);
    localparam logic [IOMEM_ADDR_W-1:0] RAM_LIMIT = RAM_BASE + RAM_WORDS * IOMEM_STRB_W;

    // GPIO register map
    localparam logic [IOMEM_ADDR_W-1:0] GPIO_DIR_ADDR    = 32'h2000_0000;
    localparam logic [IOMEM_ADDR_W-1:0] GPIO_INPUT_ADDR  = 32'h2000_0004;
    localparam logic [IOMEM_ADDR_W-1:0] GPIO_OUTPUT_ADDR = 32'h2000_0008;
    localparam int                      GPIO_NR          = 8;

    // LED matrix, 8 columns by 4 rows
    localparam logic [IOMEM_ADDR_W-1:0] LED_FB_ADDR    = 32'h3000_0000;
    localparam int                      LED_ROWS       = 4;
    localparam int                      LED_COLS       = 8;
    localparam int                      LED_ROW_W      = $clog2(LED_ROWS);
    localparam int                      LED_SCAN_DIV   = 4;
    localparam int                      LED_SCAN_CNT_W = $clog2(LED_SCAN_DIV);

    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_GPIO,
        TGT_LED,
        TGT_NONE
    } iomem_target_e;

    // Bus side sees one word, scanner sees row bytes (row 0 in the low byte)
    typedef union packed {
        logic [IOMEM_DATA_W-1:0]           word;
        logic [LED_ROWS-1:0][LED_COLS-1:0] rows;
    } led_fb_word_u;

endpackage

`default_nettype wire
